// ==== bus_top.f ====
+incdir+hw
hw/bus_pkg.sv
hw/bus_req_if.sv
hw/bus_addr_decode.sv
hw/bus_arbiter.sv
hw/bus_read_return.sv
hw/clint_timer.sv
hw/bus_top.sv
verification/tb_clk_gen.sv
verification/axi_mem_model.sv
verification/bus_tb.sv

// ==== hw/bus_addr_decode.sv ====
`timescale 1ns/1ps
`include "bus_defines.svh"

module bus_addr_decode (
  input  logic [`BUS_ADDR_W-1:0] lsu_araddr_i,
  input  logic                   lsu_arvalid_i,
  input  logic [7:0]             lsu_rstrb_i,
  input  logic [`BUS_ADDR_W-1:0] lsu_awaddr_i,
  input  logic                   lsu_awvalid_i,
  input  logic [`BUS_DATA_W-1:0] lsu_wdata_i,
  input  logic [7:0]             lsu_wstrb_i,
  bus_req_if.src                 req
);
  import bus_pkg::*;

  logic                   timer_hit;
  logic [7:0]             strb_sel;
  logic [1:0]             byte_off;
  logic [`BUS_DATA_W-1:0] wdata_sh;
  logic [3:0]             lane_strb;

  assign timer_hit = (lsu_araddr_i == `BUS_MTIME_LO_ADDR) ||
                     (lsu_araddr_i == `BUS_MTIME_HI_ADDR);

  // a store wins over a load presented in the same cycle
  assign req.is_store  = lsu_awvalid_i;
  assign req.is_load   = lsu_arvalid_i & ~lsu_awvalid_i;
  assign req.timer_sel = lsu_arvalid_i & ~lsu_awvalid_i & timer_hit;
  assign req.addr      = lsu_awvalid_i ? lsu_awaddr_i : lsu_araddr_i;

  assign strb_sel = lsu_awvalid_i ? lsu_wstrb_i : lsu_rstrb_i;

  always_comb
  begin
    case (strb_sel)
      8'h01:   req.size = BYTE;
      8'h03:   req.size = HALF;
      8'h0f:   req.size = WORD;
      default: req.size = BYTE;
    endcase
  end

  assign byte_off = lsu_awaddr_i[1:0];

  // shift into the addressed byte, same word on both halves
  assign wdata_sh  = lsu_wdata_i << {byte_off, 3'b000};
  assign req.wdata = {wdata_sh, wdata_sh};

  assign lane_strb = lsu_wstrb_i[3:0] << byte_off;
  assign req.wstrb = lsu_awaddr_i[2] ? {lane_strb, 4'b0000} : {4'b0000, lane_strb};

endmodule

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/1ps
`include "bus_defines.svh"

module bus_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`BUS_ADDR_W-1:0]     ifu_araddr_i,
  input  logic                       ifu_arvalid_i,
  bus_req_if.arb                     req,
  // AXI master
  output logic [`BUS_ADDR_W-1:0]     araddr_o,
  output bus_pkg::axi_size_t         arsize_o,
  output logic                       arvalid_o,
  input  logic                       arready_i,
  input  logic                       rvalid_i,
  output logic                       rready_o,
  output logic [`BUS_ADDR_W-1:0]     awaddr_o,
  output bus_pkg::axi_size_t         awsize_o,
  output logic                       awvalid_o,
  input  logic                       awready_i,
  output logic [`BUS_AXI_DATA_W-1:0] wdata_o,
  output logic [7:0]                 wstrb_o,
  output logic                       wlast_o,
  output logic                       wvalid_o,
  input  logic                       wready_i,
  input  logic                       bvalid_i,
  output logic                       bready_o,
  // to read return
  output logic                       grant_lsu_o,
  output logic                       data_phase_o,
  output logic                       rd_addr_bit2_o,
  output logic                       lsu_wready_o
);
  import bus_pkg::*;

  arb_state_t             state_q;
  arb_state_t             state_d;
  logic                   aw_done_q;
  logic                   w_done_q;
  logic [`BUS_ADDR_W-1:0] addr_q;
  logic                   lsu_pend;
  logic                   ar_hs;
  logic                   aw_ok;
  logic                   w_ok;

  assign lsu_pend = req.is_load | req.is_store;
  assign ar_hs    = arvalid_o & arready_i;
  assign aw_ok    = aw_done_q | (awvalid_o & awready_i);
  assign w_ok     = w_done_q | (wvalid_o & wready_i);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (lsu_pend)
          state_d = LS_ADDR;  // LSU first
        else if (ifu_arvalid_i)
          state_d = IF_ADDR;
      IF_ADDR:
        if (ar_hs)
          state_d = IF_DATA;
      IF_DATA:
        if (rvalid_i)
          state_d = IDLE;
      LS_ADDR:
      begin
        if (req.timer_sel)
          state_d = LS_DATA;  // timer answers, no AR
        else if (req.is_load && ar_hs)
          state_d = LS_DATA;
        else if (req.is_store && aw_ok && w_ok)
          state_d = LS_RESP;
      end
      LS_DATA:
        if (req.timer_sel || rvalid_i)
          state_d = IDLE;
      LS_RESP:
        if (bvalid_i)
          state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == LS_ADDR && state_d == LS_ADDR)
      begin
        aw_done_q <= aw_ok;
        w_done_q  <= w_ok;
      end
      else
      begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end
    end
  end

  // address of whichever request gets the bus
  always_ff @(posedge clk)
  begin
    if (state_q == IDLE)
      addr_q <= lsu_pend ? req.addr : ifu_araddr_i;
  end

  assign araddr_o  = addr_q;
  assign arsize_o  = (state_q == IF_ADDR) ? WORD : req.size;  // fetch is always a word
  assign arvalid_o = (state_q == IF_ADDR) ||
                     (state_q == LS_ADDR && req.is_load && !req.timer_sel);
  assign rready_o  = (state_q == IF_DATA) || (state_q == LS_DATA && !req.timer_sel);

  assign awaddr_o  = addr_q;
  assign awsize_o  = req.size;
  assign awvalid_o = (state_q == LS_ADDR) && req.is_store && !aw_done_q;
  assign wdata_o   = req.wdata;
  assign wstrb_o   = req.wstrb;
  assign wvalid_o  = (state_q == LS_ADDR) && req.is_store && !w_done_q;
  assign wlast_o   = wvalid_o;
  assign bready_o  = (state_q == LS_RESP);

  assign lsu_wready_o   = (state_q == LS_RESP) && bvalid_i;
  assign grant_lsu_o    = (state_q == LS_ADDR) || (state_q == LS_DATA) || (state_q == LS_RESP);
  assign data_phase_o   = (state_q == IF_DATA) || (state_q == LS_DATA);
  assign rd_addr_bit2_o = addr_q[2];

endmodule

// ==== hw/bus_defines.svh ====
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// core side and AXI widths
`define BUS_ADDR_W      32
`define BUS_DATA_W      32
`define BUS_AXI_DATA_W  64

// core-local timer words
`define BUS_MTIME_LO_ADDR 32'h0200_BFF8
`define BUS_MTIME_HI_ADDR 32'h0200_BFFC

`endif

// ==== hw/bus_pkg.sv ====
package bus_pkg;

  // bridge FSM states
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    IF_ADDR = 3'd1,
    IF_DATA = 3'd2,
    LS_ADDR = 3'd3,
    LS_DATA = 3'd4,
    LS_RESP = 3'd5
  } arb_state_t;

  // AXI arsize / awsize encodings, single beat only
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } axi_size_t;

endpackage

// ==== hw/bus_read_return.sv ====
`timescale 1ns/1ps
`include "bus_defines.svh"

module bus_read_return (
  input  logic                       clk,
  input  logic                       rst,
  bus_req_if.ret                     req,
  input  logic                       grant_lsu_i,
  input  logic                       data_phase_i,
  input  logic                       rd_addr_bit2_i,
  input  logic [`BUS_AXI_DATA_W-1:0] rdata_i,
  input  logic                       rvalid_i,
  input  logic [`BUS_DATA_W-1:0]     timer_rdata_i,
  input  logic                       timer_rvalid_i,
  output logic [`BUS_DATA_W-1:0]     ifu_rdata_o,
  output logic                       ifu_rvalid_o,
  output logic [`BUS_DATA_W-1:0]     lsu_rdata_o,
  output logic                       lsu_rvalid_o
);

  logic [`BUS_DATA_W-1:0] rd_half;
  logic [`BUS_DATA_W-1:0] lsu_word;
  logic [`BUS_DATA_W-1:0] ifu_hold_q;
  logic [`BUS_DATA_W-1:0] lsu_hold_q;

  assign rd_half  = rd_addr_bit2_i ? rdata_i[63:32] : rdata_i[31:0];
  assign lsu_word = req.timer_sel ? timer_rdata_i : rd_half;

  assign ifu_rvalid_o = data_phase_i & ~grant_lsu_i & rvalid_i;
  assign lsu_rvalid_o = data_phase_i & grant_lsu_i & req.is_load &
                        (req.timer_sel ? timer_rvalid_i : rvalid_i);

  // last returned word stays visible after the pulse
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ifu_hold_q <= '0;
      lsu_hold_q <= '0;
    end
    else
    begin
      if (ifu_rvalid_o)
        ifu_hold_q <= rd_half;
      if (lsu_rvalid_o)
        lsu_hold_q <= lsu_word;
    end
  end

  assign ifu_rdata_o = ifu_rvalid_o ? rd_half : ifu_hold_q;
  assign lsu_rdata_o = lsu_rvalid_o ? lsu_word : lsu_hold_q;

endmodule

// ==== hw/bus_req_if.sv ====
`timescale 1ns/1ps
`include "bus_defines.svh"

interface bus_req_if;
  import bus_pkg::*;

  logic                       is_load;
  logic                       is_store;
  logic                       timer_sel;  // load hits an mtime word
  axi_size_t                  size;
  logic [`BUS_ADDR_W-1:0]     addr;
  logic [`BUS_AXI_DATA_W-1:0] wdata;      // already lane aligned
  logic [7:0]                 wstrb;

  modport src (
    output is_load, is_store, timer_sel, size, addr, wdata, wstrb
  );

  modport arb (
    input is_load, is_store, timer_sel, size, addr, wdata, wstrb
  );

  modport ret (
    input is_load, timer_sel
  );

endinterface

// ==== hw/bus_top.sv ====
`timescale 1ns/1ps
`include "bus_defines.svh"

module bus_top (
  input  logic                       clk,
  input  logic                       rst,
  // instruction fetch
  input  logic [`BUS_ADDR_W-1:0]     ifu_araddr_i,
  input  logic                       ifu_arvalid_i,
  output logic [`BUS_DATA_W-1:0]     ifu_rdata_o,
  output logic                       ifu_rvalid_o,
  // load/store
  input  logic [`BUS_ADDR_W-1:0]     lsu_araddr_i,
  input  logic                       lsu_arvalid_i,
  input  logic [7:0]                 lsu_rstrb_i,
  output logic [`BUS_DATA_W-1:0]     lsu_rdata_o,
  output logic                       lsu_rvalid_o,
  input  logic [`BUS_ADDR_W-1:0]     lsu_awaddr_i,
  input  logic                       lsu_awvalid_i,
  input  logic [`BUS_DATA_W-1:0]     lsu_wdata_i,
  input  logic [7:0]                 lsu_wstrb_i,
  output logic                       lsu_wready_o,
  // AXI4 master
  output logic [`BUS_ADDR_W-1:0]     io_master_araddr_o,
  output logic [2:0]                 io_master_arsize_o,
  output logic                       io_master_arvalid_o,
  input  logic                       io_master_arready_i,
  input  logic [`BUS_AXI_DATA_W-1:0] io_master_rdata_i,
  input  logic                       io_master_rvalid_i,
  output logic                       io_master_rready_o,
  output logic [`BUS_ADDR_W-1:0]     io_master_awaddr_o,
  output logic [2:0]                 io_master_awsize_o,
  output logic                       io_master_awvalid_o,
  input  logic                       io_master_awready_i,
  output logic [`BUS_AXI_DATA_W-1:0] io_master_wdata_o,
  output logic [7:0]                 io_master_wstrb_o,
  output logic                       io_master_wlast_o,
  output logic                       io_master_wvalid_o,
  input  logic                       io_master_wready_i,
  input  logic                       io_master_bvalid_i,
  output logic                       io_master_bready_o
);

  bus_req_if req_if ();

  logic                   grant_lsu;
  logic                   data_phase;
  logic                   rd_addr_bit2;
  logic                   timer_rd_en;
  logic [`BUS_DATA_W-1:0] timer_rdata;
  logic                   timer_rvalid;

  // one pulse while the timer load sits in LS_ADDR
  assign timer_rd_en = req_if.timer_sel & grant_lsu & ~data_phase;

  bus_addr_decode decode_i (
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_rstrb_i   (lsu_rstrb_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_awvalid_i (lsu_awvalid_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .req           (req_if.src)
  );

  bus_arbiter arbiter_i (
    .clk            (clk),
    .rst            (rst),
    .ifu_araddr_i   (ifu_araddr_i),
    .ifu_arvalid_i  (ifu_arvalid_i),
    .req            (req_if.arb),
    .araddr_o       (io_master_araddr_o),
    .arsize_o       (io_master_arsize_o),
    .arvalid_o      (io_master_arvalid_o),
    .arready_i      (io_master_arready_i),
    .rvalid_i       (io_master_rvalid_i),
    .rready_o       (io_master_rready_o),
    .awaddr_o       (io_master_awaddr_o),
    .awsize_o       (io_master_awsize_o),
    .awvalid_o      (io_master_awvalid_o),
    .awready_i      (io_master_awready_i),
    .wdata_o        (io_master_wdata_o),
    .wstrb_o        (io_master_wstrb_o),
    .wlast_o        (io_master_wlast_o),
    .wvalid_o       (io_master_wvalid_o),
    .wready_i       (io_master_wready_i),
    .bvalid_i       (io_master_bvalid_i),
    .bready_o       (io_master_bready_o),
    .grant_lsu_o    (grant_lsu),
    .data_phase_o   (data_phase),
    .rd_addr_bit2_o (rd_addr_bit2),
    .lsu_wready_o   (lsu_wready_o)
  );

  bus_read_return result_i (
    .clk            (clk),
    .rst            (rst),
    .req            (req_if.ret),
    .grant_lsu_i    (grant_lsu),
    .data_phase_i   (data_phase),
    .rd_addr_bit2_i (rd_addr_bit2),
    .rdata_i        (io_master_rdata_i),
    .rvalid_i       (io_master_rvalid_i),
    .timer_rdata_i  (timer_rdata),
    .timer_rvalid_i (timer_rvalid),
    .ifu_rdata_o    (ifu_rdata_o),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_rdata_o    (lsu_rdata_o),
    .lsu_rvalid_o   (lsu_rvalid_o)
  );

  clint_timer timer_i (
    .clk       (clk),
    .rst       (rst),
    .rd_addr_i (req_if.addr),
    .rd_en_i   (timer_rd_en),
    .rdata_o   (timer_rdata),
    .rvalid_o  (timer_rvalid)
  );

endmodule

// ==== hw/clint_timer.sv ====
`timescale 1ns/1ps
`include "bus_defines.svh"

module clint_timer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`BUS_ADDR_W-1:0] rd_addr_i,
  input  logic                   rd_en_i,
  output logic [`BUS_DATA_W-1:0] rdata_o,
  output logic                   rvalid_o
);

  logic [63:0] mtime_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q  <= '0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      mtime_q  <= mtime_q + 64'd1;  // free running
      rvalid_o <= rd_en_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_en_i)
      rdata_o <= (rd_addr_i == `BUS_MTIME_HI_ADDR) ? mtime_q[63:32] : mtime_q[31:0];
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator, result decided from sim.log
verilator --binary --timing --assert -f bus_top.f --top-module bus_tb -o bus_sim \
  > build.log 2>&1 \
  && ./obj_dir/bus_sim > sim.log 2>&1 \
  || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "FAIL: see errors" sim.log \
  && { echo "simulation reported errors"; exit 1; } \
  || { echo "simulation clean"; exit 0; }

// ==== verification/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [63:0] rdata_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  input  logic [31:0] awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [63:0] wdata_i,
  input  logic [7:0]  wstrb_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic        bvalid_o,
  input  logic        bready_i
);

  logic [63:0] mem [0:255];
  logic [1:0]  rd_st;
  logic [1:0]  b_st;
  logic [1:0]  ar_cnt;
  logic [1:0]  r_cnt;
  logic [1:0]  aw_cnt;
  logic [1:0]  w_cnt;
  logic [1:0]  b_cnt;
  logic [31:0] raddr;
  logic [31:0] waddr;
  logic [63:0] wdata_l;
  logic [7:0]  wstrb_l;
  logic        aw_got;
  logic        w_got;

  // byte value depends on the full byte address
  initial
  begin
    logic [31:0] a;
    for (int i = 0; i < 256; i++)
    begin
      for (int b = 0; b < 8; b++)
      begin
        a = 32'(i * 8 + b);
        mem[i][8*b +: 8] = 8'(a * 32'd7) ^ a[15:8] ^ 8'h5a;
      end
    end
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      rd_st     <= 2'd0;
      b_st      <= 2'd0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      ar_cnt    <= 2'($urandom);
      aw_cnt    <= 2'($urandom);
      w_cnt     <= 2'($urandom);
    end
    else
    begin
      // read address and data
      case (rd_st)
        2'd0:
          if (arvalid_i && arready_o)
          begin
            arready_o <= 1'b0;
            raddr     <= araddr_i;
            ar_cnt    <= 2'($urandom);
            r_cnt     <= 2'($urandom);
            rd_st     <= 2'd1;
          end
          else if (arvalid_i)
          begin
            if (ar_cnt == 2'd0)
              arready_o <= 1'b1;
            else
              ar_cnt <= ar_cnt - 2'd1;
          end
        2'd1:
          if (r_cnt == 2'd0)
          begin
            rvalid_o <= 1'b1;
            rdata_o  <= mem[raddr[10:3]];
            rd_st    <= 2'd2;
          end
          else
            r_cnt <= r_cnt - 2'd1;
        default:
          if (rready_i)
          begin
            rvalid_o <= 1'b0;
            rd_st    <= 2'd0;
          end
      endcase

      // write address and data channels run on their own
      if (awvalid_i && awready_o)
      begin
        awready_o <= 1'b0;
        waddr     <= awaddr_i;
        aw_got    <= 1'b1;
        aw_cnt    <= 2'($urandom);
      end
      else if (awvalid_i && !aw_got)
      begin
        if (aw_cnt == 2'd0)
          awready_o <= 1'b1;
        else
          aw_cnt <= aw_cnt - 2'd1;
      end

      if (wvalid_i && wready_o)
      begin
        wready_o <= 1'b0;
        wdata_l  <= wdata_i;
        wstrb_l  <= wstrb_i;
        w_got    <= 1'b1;
        w_cnt    <= 2'($urandom);
      end
      else if (wvalid_i && !w_got)
      begin
        if (w_cnt == 2'd0)
          wready_o <= 1'b1;
        else
          w_cnt <= w_cnt - 2'd1;
      end

      case (b_st)
        2'd0:
          if (aw_got && w_got)
          begin
            for (int j = 0; j < 8; j++)
              if (wstrb_l[j])
                mem[waddr[10:3]][8*j +: 8] <= wdata_l[8*j +: 8];
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            b_cnt  <= 2'($urandom);
            b_st   <= 2'd1;
          end
        2'd1:
          if (b_cnt == 2'd0)
          begin
            bvalid_o <= 1'b1;
            b_st     <= 2'd2;
          end
          else
            b_cnt <= b_cnt - 2'd1;
        default:
          if (bready_i)
          begin
            bvalid_o <= 1'b0;
            b_st     <= 2'd0;
          end
      endcase
    end
  end

endmodule

// ==== verification/bus_tb.sv ====
`timescale 1ns/1ps
`include "bus_defines.svh"

module bus_tb;

  localparam int TIMEOUT = 64;

  logic        clk;
  logic        rst;
  logic [31:0] ifu_araddr_i;
  logic        ifu_arvalid_i;
  logic [31:0] ifu_rdata_o;
  logic        ifu_rvalid_o;
  logic [31:0] lsu_araddr_i;
  logic        lsu_arvalid_i;
  logic [7:0]  lsu_rstrb_i;
  logic [31:0] lsu_rdata_o;
  logic        lsu_rvalid_o;
  logic [31:0] lsu_awaddr_i;
  logic        lsu_awvalid_i;
  logic [31:0] lsu_wdata_i;
  logic [7:0]  lsu_wstrb_i;
  logic        lsu_wready_o;
  logic [31:0] araddr;
  logic [2:0]  arsize;
  logic        arvalid;
  logic        arready;
  logic [63:0] rdata;
  logic        rvalid;
  logic        rready;
  logic [31:0] awaddr;
  logic [2:0]  awsize;
  logic        awvalid;
  logic        awready;
  logic [63:0] wdata;
  logic [7:0]  wstrb;
  logic        wlast;
  logic        wvalid;
  logic        wready;
  logic        bvalid;
  logic        bready;

  logic [7:0]  ref_mem [0:2047];
  int          errors;
  int          timeouts;
  int          cycle;
  int          ar_count;
  logic        first_seen;
  logic [31:0] first_addr;
  logic        p_arvalid;
  logic        p_arready;
  logic        p_awvalid;
  logic        p_awready;
  logic        p_wvalid;
  logic        p_wready;
  logic [31:0] p_araddr;
  logic [31:0] p_awaddr;
  logic [63:0] p_wdata;
  logic [7:0]  p_wstrb;

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(3)) clk_gen_i (.clk_o(clk), .rst_o(rst));

  bus_top dut_i (
    .clk(clk), .rst(rst),
    .ifu_araddr_i(ifu_araddr_i), .ifu_arvalid_i(ifu_arvalid_i),
    .ifu_rdata_o(ifu_rdata_o), .ifu_rvalid_o(ifu_rvalid_o),
    .lsu_araddr_i(lsu_araddr_i), .lsu_arvalid_i(lsu_arvalid_i), .lsu_rstrb_i(lsu_rstrb_i),
    .lsu_rdata_o(lsu_rdata_o), .lsu_rvalid_o(lsu_rvalid_o),
    .lsu_awaddr_i(lsu_awaddr_i), .lsu_awvalid_i(lsu_awvalid_i),
    .lsu_wdata_i(lsu_wdata_i), .lsu_wstrb_i(lsu_wstrb_i), .lsu_wready_o(lsu_wready_o),
    .io_master_araddr_o(araddr), .io_master_arsize_o(arsize),
    .io_master_arvalid_o(arvalid), .io_master_arready_i(arready),
    .io_master_rdata_i(rdata), .io_master_rvalid_i(rvalid), .io_master_rready_o(rready),
    .io_master_awaddr_o(awaddr), .io_master_awsize_o(awsize),
    .io_master_awvalid_o(awvalid), .io_master_awready_i(awready),
    .io_master_wdata_o(wdata), .io_master_wstrb_o(wstrb), .io_master_wlast_o(wlast),
    .io_master_wvalid_o(wvalid), .io_master_wready_i(wready),
    .io_master_bvalid_i(bvalid), .io_master_bready_o(bready)
  );

  axi_mem_model mem_i (
    .clk(clk), .rst(rst),
    .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
    .rdata_o(rdata), .rvalid_o(rvalid), .rready_i(rready),
    .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
    .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
    .bvalid_o(bvalid), .bready_i(bready)
  );

  task automatic report_fail(input string msg);
    errors++;
    $display("Fail %0t: %s", $time, msg);
  endtask

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    logic [10:0] a;
    a = {addr[10:2], 2'b00};
    return {ref_mem[a + 11'd3], ref_mem[a + 11'd2], ref_mem[a + 11'd1], ref_mem[a]};
  endfunction

  // AXI size code for an LSU strobe pattern
  function automatic logic [2:0] size_for_strb(input logic [7:0] strb);
    case (strb)
      8'h03:   return 3'd1;
      8'h0f:   return 3'd2;
      default: return 3'd0;
    endcase
  endfunction

  always @(posedge clk)
    cycle++;

  // AXI stability under back-pressure, AR count and first address
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (p_arvalid && !p_arready)
        assert (arvalid && araddr == p_araddr)
          else report_fail("AR dropped or araddr changed before arready");
      if (p_awvalid && !p_awready)
        assert (awvalid && awaddr == p_awaddr)
          else report_fail("AW dropped or awaddr changed before awready");
      if (p_wvalid && !p_wready)
        assert (wvalid && wdata == p_wdata && wstrb == p_wstrb)
          else report_fail("W dropped or wdata/wstrb changed before wready");
      assert (wlast == wvalid) else report_fail("wlast differs from wvalid");
      if (arvalid && arready)
        ar_count++;
      if (!first_seen && (arvalid || awvalid))
      begin
        first_seen = 1'b1;
        first_addr = arvalid ? araddr : awaddr;
      end
    end
    p_arvalid = arvalid;
    p_arready = arready;
    p_awvalid = awvalid;
    p_awready = awready;
    p_wvalid  = wvalid;
    p_wready  = wready;
    p_araddr  = araddr;
    p_awaddr  = awaddr;
    p_wdata   = wdata;
    p_wstrb   = wstrb;
  end

  task automatic ifu_fetch(input logic [31:0] addr, output logic [31:0] data);
    int n;
    @(posedge clk);
    #1;
    ifu_araddr_i  = addr;
    ifu_arvalid_i = 1'b1;
    n = 0;
    @(negedge clk);
    while (!ifu_rvalid_o && n < TIMEOUT)
    begin
      if (arvalid && araddr == addr)
        assert (arsize == 3'd2)  // a fetch is a full word
          else report_fail($sformatf("fetch %h arsize %0d", addr, arsize));
      n++;
      @(negedge clk);
    end
    if (!ifu_rvalid_o)
    begin
      timeouts++;
      $display("timeout: fetch at %h never returned data", addr);
    end
    data = ifu_rdata_o;
    @(posedge clk);
    #1 ifu_arvalid_i = 1'b0;
  endtask

  task automatic lsu_load(input logic [31:0] addr, input logic [7:0] strb,
                          output logic [31:0] data, output int lat, output int start);
    logic [2:0] exp_size;
    exp_size = size_for_strb(strb);
    @(posedge clk);
    #1;
    start         = cycle;
    lsu_araddr_i  = addr;
    lsu_rstrb_i   = strb;
    lsu_arvalid_i = 1'b1;
    lat = 0;
    @(negedge clk);
    while (!lsu_rvalid_o && lat < TIMEOUT)
    begin
      if (arvalid && araddr == addr)
        assert (arsize == exp_size)
          else report_fail($sformatf("load %h arsize %0d", addr, arsize));
      lat++;  // edges passed since the request
      @(negedge clk);
    end
    if (!lsu_rvalid_o)
    begin
      timeouts++;
      $display("timeout: load at %h never returned data", addr);
    end
    data = lsu_rdata_o;
    @(posedge clk);
    #1 lsu_arvalid_i = 1'b0;
  endtask

  task automatic lsu_store(input logic [31:0] addr, input logic [31:0] data,
                           input logic [7:0] strb);
    logic [31:0] sh;
    logic [3:0]  lane;
    logic [63:0] exp_wdata;
    logic [7:0]  exp_wstrb;
    logic [2:0]  exp_size;
    logic [10:0] base;
    int          n;
    int          off;
    int          src;
    off  = int'(addr[1:0]);
    sh   = '0;
    lane = '0;
    // byte j of the word comes from byte j - off of the store data
    for (int j = 0; j < 4; j++)
    begin
      src = j - off;
      if (src >= 0)
      begin
        sh[8*j +: 8] = data[8*src +: 8];
        lane[j]      = strb[src];
      end
    end
    exp_wdata = {sh, sh};
    for (int j = 0; j < 8; j++)
      exp_wstrb[j] = (j / 4 == int'(addr[2])) && lane[j % 4];
    exp_size = size_for_strb(strb);
    @(posedge clk);
    #1;
    lsu_awaddr_i  = addr;
    lsu_wdata_i   = data;
    lsu_wstrb_i   = strb;
    lsu_awvalid_i = 1'b1;
    n = 0;
    @(negedge clk);
    while (!lsu_wready_o && n < TIMEOUT)
    begin
      if (awvalid)
        assert (awaddr == addr && awsize == exp_size)
          else report_fail($sformatf("store %h awaddr %h awsize %0d", addr, awaddr, awsize));
      if (wvalid)
        assert (wdata == exp_wdata && wstrb == exp_wstrb)
          else report_fail($sformatf("store %h wdata %h wstrb %h", addr, wdata, wstrb));
      n++;
      @(negedge clk);
    end
    if (!lsu_wready_o)
    begin
      timeouts++;
      $display("timeout: store at %h never got a write response", addr);
    end
    base = {addr[10:3], 3'b000};
    for (int j = 0; j < 8; j++)
      if (exp_wstrb[j])
        ref_mem[base + 11'(j)] = exp_wdata[8*j +: 8];
    @(posedge clk);
    #1 lsu_awvalid_i = 1'b0;
  endtask

  initial
  begin
    logic [31:0] got;
    logic [31:0] got2;
    logic [31:0] addr;
    logic [31:0] data;
    logic [7:0]  strbs [3];
    int          lat;
    int          lat2;
    int          c1;
    int          c2;
    int          n;
    int          ar_before;
    logic [10:0] a;

    void'($urandom(24));
    strbs = '{8'h01, 8'h03, 8'h0f};
    errors = 0;
    timeouts = 0;
    cycle = 0;
    ar_count = 0;
    first_seen = 1'b0;
    first_addr = '0;
    ifu_araddr_i = '0;
    ifu_arvalid_i = 1'b0;
    lsu_araddr_i = '0;
    lsu_arvalid_i = 1'b0;
    lsu_rstrb_i = '0;
    lsu_awaddr_i = '0;
    lsu_awvalid_i = 1'b0;
    lsu_wdata_i = '0;
    lsu_wstrb_i = '0;
    for (int i = 0; i < 2048; i++)
    begin
      a = 11'(i);
      ref_mem[i] = 8'(32'(i) * 32'd7) ^ {5'b0, a[10:8]} ^ 8'h5a;
    end

    n = 0;
    @(negedge clk);
    while (rst && n < TIMEOUT)
    begin
      n++;
      @(negedge clk);
    end
    if (rst)
    begin
      timeouts++;
      $display("timeout: reset was never released");
    end

    repeat (2)
    begin
      assert (!arvalid && !awvalid && !wvalid && !rready && !bready)
        else report_fail("AXI valid or ready output high after reset");
      assert (!ifu_rvalid_o && !lsu_rvalid_o && !lsu_wready_o)
        else report_fail("response pulse high after reset");
      @(negedge clk);
    end

    // timer reads, early in the run
    ar_before = ar_count;
    lsu_load(`BUS_MTIME_HI_ADDR, 8'h0f, got, lat, c1);
    assert (got == 32'd0) else report_fail($sformatf("mtime high word %h", got));
    lsu_load(`BUS_MTIME_LO_ADDR, 8'h0f, got, lat, c1);
    repeat (7) @(posedge clk);
    lsu_load(`BUS_MTIME_LO_ADDR, 8'h0f, got2, lat2, c2);
    assert (lat == 2 && lat2 == 2)
      else report_fail($sformatf("timer latency %0d and %0d", lat, lat2));
    assert (got2 - got == 32'(c2 - c1))
      else report_fail($sformatf("mtime delta %0d over %0d cycles", got2 - got, c2 - c1));
    assert (ar_count == ar_before) else report_fail("timer load issued an AR");

    for (int i = 0; i < 4; i++)
    begin
      addr = 32'h40 + 32'(i * 4);
      ifu_fetch(addr, got);
      assert (got == ref_word(addr))
        else report_fail($sformatf("fetch %h got %h", addr, got));
    end

    for (int off = 0; off < 4; off++)
    begin
      for (int k = 0; k < 3; k++)
      begin
        n = off * 3 + k;
        addr = 32'h200 + 32'(n * 8) + ((n % 2 == 1) ? 32'd4 : 32'd0) + 32'(off);
        data = $urandom;
        lsu_store(addr, data, strbs[k]);
        lsu_load({addr[31:2], 2'b00}, strbs[k], got, lat, c1);
        assert (got == ref_word(addr))
          else report_fail($sformatf("load after store %h got %h", addr, got));
      end
    end

    // LSU and IFU request in the same idle cycle
    first_seen = 1'b0;
    fork
      ifu_fetch(32'h88, got);
      lsu_load(32'h304, 8'h0f, got2, lat, c1);
    join
    assert (first_seen && first_addr == 32'h304)
      else report_fail($sformatf("first address %h, LSU not first", first_addr));
    assert (got == ref_word(32'h88)) else report_fail("fetch after LSU wrong data");
    assert (got2 == ref_word(32'h304)) else report_fail("LSU load with IFU wrong data");

    repeat (2) @(posedge clk);
    $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;  // released just after the last reset edge
  end

endmodule
